// File: project.f
verilog/vga_pkg.sv
verilog/vga_registers.sv
verilog/vga_timing.sv
verilog/vga_cursor.sv
verilog/vga_display_top.sv
tb/vga_display_tb.sv

// File: tb/vga_regs_vectors.txt
# columns: op offset bytesel data expect, all hex
# cursor lines: op row col scan(start,end nibbles) expected pixel count per frame
read   4 1 0000 0000
write  2 1 000A 0000
read   2 2 0000 1000
read   2 1 0000 000A
write  2 2 0300 0000
read   2 3 0000 030A
write  2 3 060B 0000
read   2 3 0000 060B
write  2 3 060E 0000
read   2 3 0000 060E
write  2 3 610F 0000
read   2 3 0000 610F
write  2 1 0007 0000
read   2 3 0000 0007
write  4 2 5500 0000
read   4 2 0000 0000
read   4 1 0000 0000
ports  0 0 0000 0000
write  4 1 0002 0000
read   4 1 0000 0002
ports  0 0 0000 0002
write  4 1 0009 0000
write  4 2 00FF 0000
read   4 3 0000 0009
ports  0 0 0000 0001
vread  5 1 0000 0001
aread  5 1 0000 0008
cursor 14 21 36 0020
write  2 3 000E 0000
write  2 3 4F0F 0000
write  2 3 000A 0000
write  2 3 0F0B 0000
read   2 3 0000 0F0B
cursor 00 4F 0F 0080
write  2 3 100A 0000
read   2 3 0000 100A
cursor 00 4F 0F 0000

// File: tb/vga_display_tb.sv
module vga_display_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import vga_pkg::*;

    localparam int     ack_limit    = 16;
    localparam longint frame_cycles = h_total * v_total;

    logic     clk;
    logic     reset;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    logic     hsync;
    logic     vsync;
    logic     de;
    logic     cursor_pixel;
    logic     graphics_enabled;
    logic     text_enabled;

    string       op_q[$];
    logic [15:0] arg_a[$];
    logic [15:0] arg_b[$];
    logic [15:0] arg_d[$];
    logic [15:0] arg_e[$];
    longint      watchdog_ns;

    // frame monitor state is owned by the negedge monitor below
    logic measure_req;
    logic measure_on;
    logic frame_done;
    logic hsync_q;
    logic vsync_q;
    logic de_q;
    int   line_num;
    int   px_num;
    int   exp_row;
    int   exp_col;
    int   exp_scan_lo;
    int   exp_scan_hi;
    int   pixel_count;
    int   hsync_falls;
    int   de_rises;

    vga_display_top uut (
        .clk              (clk),
        .reset            (reset),
        .bus_req          (bus_req),
        .bus_rsp          (bus_rsp),
        .hsync            (hsync),
        .vsync            (vsync),
        .de               (de),
        .cursor_pixel     (cursor_pixel),
        .graphics_enabled (graphics_enabled),
        .text_enabled     (text_enabled)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       text;
        string       op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] d;
        logic [15:0] e;
        fd = $fopen("tb/vga_regs_vectors.txt", "r");
        if (fd == 0)
            abort_run("cannot open the vector file tb/vga_regs_vectors.txt");
        while (!$feof(fd)) begin
            n = $fgets(text, fd);
            if (n > 0 && text.getc(0) != "#") begin
                n = $sscanf(text, "%s %h %h %h %h", op, a, b, d, e);
                if (n == 5) begin
                    op_q.push_back(op);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                    arg_d.push_back(d);
                    arg_e.push_back(e);
                end else if (n > 0) begin
                    abort_run({"malformed vector line: ", text});
                end
            end
        end
        $fclose(fd);
    endtask

    // one access/ack exchange, holding access one cycle past ack
    task automatic run_access(input logic [2:0] off, input logic [1:0] bytesel,
                              input logic wr, input logic [15:0] wdata,
                              output logic [15:0] rdata);
        int waited;
        @(negedge clk);
        bus_req.cs      = 1'b1;
        bus_req.addr    = {16'b0, off};
        bus_req.bytesel = bytesel;
        bus_req.wr_en   = wr;
        bus_req.wdata   = wdata;
        bus_req.access  = 1'b1;
        @(negedge clk);
        waited = 1;
        while (bus_rsp.ack !== 1'b1 && waited < ack_limit) begin
            @(negedge clk);
            waited++;
        end
        if (bus_rsp.ack !== 1'b1)
            abort_run("bus access got no ack within the access limit");
        check_value("ack latency", waited, 1);
        rdata = bus_rsp.rdata;
        if (wr)
            check_value("rdata on write", rdata, 16'h0);
        @(negedge clk);
        check_value("ack while access held", bus_rsp.ack, 1'b1);
        check_value("rdata while access held", bus_rsp.rdata, rdata);
        bus_req.access = 1'b0;
        bus_req.cs     = 1'b0;
        bus_req.wr_en  = 1'b0;
        @(negedge clk);
        check_value("ack after access drop", bus_rsp.ack, 1'b0);
    endtask

    task automatic measure_frame(input int row, input int col, input int scan_lo,
                                 input int scan_hi);
        exp_row     = row;
        exp_col     = col;
        exp_scan_lo = scan_lo;
        exp_scan_hi = scan_hi;
        frame_done  = 1'b0;
        measure_req = 1'b1;
        wait (frame_done);
    endtask

    // a frame runs from one vsync fall to the next; cursor_pixel lags the beam by one cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (measure_on && cursor_pixel) begin
                pixel_count++;
                check_value("de under cursor_pixel", de_q, 1'b1);
                check_value("cursor_pixel character row", line_num / char_h, exp_row);
                check_value("cursor_pixel character column", px_num / char_w, exp_col);
                check_value("cursor_pixel scan line in range",
                            (line_num % char_h >= exp_scan_lo) &&
                            (line_num % char_h <= exp_scan_hi), 1'b1);
            end
            if (measure_on && hsync_q && !hsync)
                hsync_falls++;
            if (!vsync)
                line_num = -1;
            if (de && !de_q) begin
                line_num++;
                px_num = 0;
                if (measure_on)
                    de_rises++;
            end else if (de) begin
                px_num++;
            end
            if (vsync_q && !vsync) begin
                if (measure_on) begin
                    measure_on = 1'b0;
                    frame_done = 1'b1;
                end else if (measure_req) begin
                    measure_req = 1'b0;
                    measure_on  = 1'b1;
                    pixel_count = 0;
                    hsync_falls = 0;
                    de_rises    = 0;
                end
            end
            hsync_q = hsync;
            vsync_q = vsync;
            de_q    = de;
        end
    end

    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        abort_run("timeout: the run did not finish within the watchdog limit");
    end

    initial begin
        logic [15:0] rdata;
        int          frame_ops;
        reset       = 1'b1;
        bus_req     = '0;
        measure_req = 1'b0;
        measure_on  = 1'b0;
        frame_done  = 1'b0;
        hsync_q     = 1'b1;
        vsync_q     = 1'b1;
        de_q        = 1'b0;
        line_num    = -1;
        px_num      = 0;
        load_vectors();
        frame_ops = 0;
        foreach (op_q[i])
            if (op_q[i] == "cursor" || op_q[i] == "vread" || op_q[i] == "aread")
                frame_ops++;
        // every frame-bound vector may wait one frame and then measure another
        watchdog_ns = ((3 + 2 * frame_ops) * frame_cycles + 100 * op_q.size()) * 4;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (op_q[i]) begin
            case (op_q[i])
                "write": run_access(arg_a[i][2:0], arg_b[i][1:0], 1'b1, arg_d[i], rdata);
                "read": begin
                    run_access(arg_a[i][2:0], arg_b[i][1:0], 1'b0, 16'h0, rdata);
                    check_value("rdata", rdata, arg_e[i]);
                end
                "ports": check_value("graphics_enabled,text_enabled",
                                     {graphics_enabled, text_enabled}, arg_e[i]);
                "vread": begin
                    while (vsync !== 1'b0)
                        @(negedge clk);
                    run_access(arg_a[i][2:0], arg_b[i][1:0], 1'b0, 16'h0, rdata);
                    check_value("status rdata during vsync", rdata, arg_e[i]);
                end
                "aread": begin
                    while (de !== 1'b1)
                        @(negedge clk);
                    run_access(arg_a[i][2:0], arg_b[i][1:0], 1'b0, 16'h0, rdata);
                    check_value("status rdata during display", rdata, arg_e[i]);
                end
                "cursor": begin
                    measure_frame(arg_a[i], arg_b[i], arg_d[i][7:4], arg_d[i][3:0]);
                    check_value("cursor_pixel count", pixel_count, arg_e[i]);
                    check_value("hsync pulses per frame", hsync_falls,
                                v_visible + v_front + v_sync + v_back);
                    check_value("de lines per frame", de_rises, v_visible);
                end
                default: abort_run({"unknown vector opcode ", op_q[i]});
            endcase
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: verilog/vga_display_top.sv
module vga_display_top (
    input  logic              clk,
    input  logic              reset,
    input  vga_pkg::bus_req_t bus_req,
    output vga_pkg::bus_rsp_t bus_rsp,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic              cursor_pixel,
    output logic              graphics_enabled,
    output logic              text_enabled
);
    import vga_pkg::*;

    beam_t       beam;
    cursor_cfg_t cursor_cfg;

    vga_registers u_registers (
        .clk              (clk),
        .reset            (reset),
        .bus_req          (bus_req),
        .bus_rsp          (bus_rsp),
        .beam             (beam),
        .cursor_cfg       (cursor_cfg),
        .graphics_enabled (graphics_enabled),
        .text_enabled     (text_enabled)
    );

    vga_timing u_timing (
        .clk   (clk),
        .reset (reset),
        .beam  (beam)
    );

    vga_cursor u_cursor (
        .clk          (clk),
        .reset        (reset),
        .beam         (beam),
        .cursor_cfg   (cursor_cfg),
        .cursor_pixel (cursor_pixel)
    );

    // video outputs come straight from the beam register
    assign hsync = beam.hsync;
    assign vsync = beam.vsync;
    assign de    = beam.de;

endmodule

// File: verilog/vga_cursor.sv
module vga_cursor (
    input  logic                 clk,
    input  logic                 reset,
    input  vga_pkg::beam_t       beam,
    input  vga_pkg::cursor_cfg_t cursor_cfg,
    output logic                 cursor_pixel
);
    import vga_pkg::*;

    // address of column 0 in the character row being scanned
    logic [cursor_pos_w-1:0] row_base;
    // address of the cell under the previous pixel
    logic [cursor_pos_w-1:0] cell_addr;
    logic [col_w-1:0]        col_q;

    logic [cursor_pos_w-1:0] line_base;
    logic [cursor_pos_w-1:0] cur_addr;
    logic                    new_cell;
    logic                    in_scan_range;

    // the first scan line of a character row moves the base on by one row
    assign line_base = (beam.scan == '0) ? row_base + cursor_pos_w'(text_cols) : row_base;

    assign new_cell = beam.col != col_q;

    always_comb begin
        if (beam.new_frame)
            cur_addr = '0;
        else if (beam.new_line)
            cur_addr = line_base;
        else if (new_cell)
            cur_addr = cell_addr + 1'b1;
        else
            cur_addr = cell_addr;
    end

    assign in_scan_range = (beam.scan >= cursor_cfg.scan_start) &&
                           (beam.scan <= cursor_cfg.scan_end);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row_base  <= '0;
            cell_addr <= '0;
            col_q     <= '0;
        end else begin
            cell_addr <= cur_addr;
            col_q     <= beam.col;
            if (beam.new_frame)
                row_base <= '0;
            else if (beam.new_line)
                row_base <= line_base;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cursor_pixel <= 1'b0;
        end else begin
            cursor_pixel <= cursor_cfg.enabled && beam.de && in_scan_range &&
                            (cur_addr == cursor_cfg.pos);
        end
    end

endmodule

// File: verilog/vga_timing.sv
module vga_timing (
    input  logic           clk,
    input  logic           reset,
    output vga_pkg::beam_t beam
);
    import vga_pkg::*;

    logic [h_count_w-1:0] h_count;
    logic [v_count_w-1:0] v_count;

    // character position kept alongside the raw counters so no divider is needed
    logic [px_w-1:0]   px_count;
    logic [col_w-1:0]  col_count;
    logic [row_w-1:0]  row_count;
    logic [scan_w-1:0] scan_count;

    logic line_end;
    logic frame_end;

    assign line_end  = h_count == h_total - 1;
    assign frame_end = v_count == v_total - 1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_count    <= '0;
            v_count    <= '0;
            px_count   <= '0;
            col_count  <= '0;
            row_count  <= '0;
            scan_count <= '0;
        end else if (line_end) begin
            h_count   <= '0;
            px_count  <= '0;
            col_count <= '0;
            if (frame_end) begin
                v_count    <= '0;
                scan_count <= '0;
                row_count  <= '0;
            end else begin
                v_count <= v_count + 1'b1;
                if (scan_count == char_h - 1) begin
                    scan_count <= '0;
                    row_count  <= row_count + 1'b1;
                end else begin
                    scan_count <= scan_count + 1'b1;
                end
            end
        end else begin
            h_count <= h_count + 1'b1;
            if (px_count == char_w - 1) begin
                px_count  <= '0;
                col_count <= col_count + 1'b1;
            end else begin
                px_count <= px_count + 1'b1;
            end
        end
    end

    // beam outputs lag the counters by one flop so every field lines up
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            beam.hsync     <= 1'b1;
            beam.vsync     <= 1'b1;
            beam.de        <= 1'b0;
            beam.col       <= '0;
            beam.row       <= '0;
            beam.scan      <= '0;
            beam.new_line  <= 1'b0;
            beam.new_frame <= 1'b0;
        end else begin
            beam.hsync     <= !(h_count >= h_sync_start && h_count < h_sync_end);
            beam.vsync     <= !(v_count >= v_sync_start && v_count < v_sync_end);
            beam.de        <= (h_count < h_visible) && (v_count < v_visible);
            beam.col       <= col_count;
            beam.row       <= row_count;
            beam.scan      <= scan_count;
            beam.new_line  <= h_count == 0;
            beam.new_frame <= (h_count == 0) && (v_count == 0);
        end
    end

    // the visible area must map exactly onto the text grid
    de_inside_grid: assert property (@(posedge clk) disable iff (reset)
        beam.de |-> (beam.col < text_cols) && (beam.row < text_rows));

endmodule

// File: verilog/vga_registers.sv
module vga_registers (
    input  logic                 clk,
    input  logic                 reset,
    input  vga_pkg::bus_req_t    bus_req,
    output vga_pkg::bus_rsp_t    bus_rsp,
    input  vga_pkg::beam_t       beam,
    output vga_pkg::cursor_cfg_t cursor_cfg,
    output logic                 graphics_enabled,
    output logic                 text_enabled
);
    import vga_pkg::*;

    logic       reg_access;
    logic [2:0] offset;
    logic       sel_index;
    logic       sel_value;
    logic       sel_mode;
    logic       sel_status;

    logic [3:0] active_index;
    logic [3:0] index;
    logic [7:0] index_value;
    logic [7:0] status;

    logic [1:0]              cursor_mode;
    logic [scan_w-1:0]       scan_start;
    logic [scan_w-1:0]       scan_end;
    logic [cursor_pos_w-1:0] cursor_pos;
    logic                    display_enabled;

    logic [15:0] rdata_q;
    logic        ack_q;

    assign reg_access = bus_req.cs & bus_req.access;
    assign offset     = bus_req.addr[3:1];

    // low lane of each word is one register, high lane another
    assign sel_index  = reg_access & (offset == reg_index_off) & bus_req.bytesel[0];
    assign sel_value  = reg_access & (offset == reg_index_off) & bus_req.bytesel[1];
    assign sel_mode   = reg_access & (offset == reg_mode_off) & bus_req.bytesel[0];
    assign sel_status = reg_access & (offset == reg_status_off) & bus_req.bytesel[0];

    // an index written in the same access steers the value lane straight away
    assign index = (bus_req.wr_en & sel_index) ? bus_req.wdata[3:0] : active_index;

    // bit 0 flags retrace on either axis, bit 3 mirrors vsync
    assign status = {4'b0, beam.vsync, 2'b0, ~beam.vsync | ~beam.hsync};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_index <= '0;
        end else if (sel_index & bus_req.wr_en) begin
            active_index <= bus_req.wdata[3:0];
        end
    end

    // the indexed bytes live in the high lane of the data bus
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cursor_mode <= 2'b01;
            scan_start  <= '0;
            scan_end    <= '0;
            cursor_pos  <= '0;
        end else if (sel_value & bus_req.wr_en) begin
            case (index)
                idx_cursor_shape: begin
                    cursor_mode <= bus_req.wdata[13:12];
                    scan_start  <= bus_req.wdata[11:8];
                end
                idx_cursor_end: scan_end <= bus_req.wdata[11:8];
                idx_cursor_hi: cursor_pos[14:8] <= bus_req.wdata[14:8];
                idx_cursor_lo: cursor_pos[7:0] <= bus_req.wdata[15:8];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            display_enabled  <= 1'b0;
            graphics_enabled <= 1'b0;
            text_enabled     <= 1'b0;
        end else if (sel_mode & bus_req.wr_en) begin
            display_enabled  <= bus_req.wdata[3];
            graphics_enabled <= bus_req.wdata[1];
            text_enabled     <= bus_req.wdata[0];
        end
    end

    always_comb begin
        case (index)
            idx_cursor_shape: index_value = {2'b0, cursor_mode, scan_start};
            idx_cursor_end:   index_value = {4'b0, scan_end};
            idx_cursor_hi:    index_value = {1'b0, cursor_pos[14:8]};
            idx_cursor_lo:    index_value = cursor_pos[7:0];
            default:          index_value = 8'b0;
        endcase
    end

    // read data is rebuilt every cycle so it drops back to zero between reads
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= '0;
            if (!bus_req.wr_en) begin
                if (sel_index)
                    rdata_q[7:0] <= {4'b0, active_index};
                if (sel_mode)
                    rdata_q[7:0] <= {4'b0, display_enabled, 1'b0,
                                     graphics_enabled, text_enabled};
                if (sel_status)
                    rdata_q[7:0] <= status;
                if (sel_value)
                    rdata_q[15:8] <= index_value;
                // the colour lane of the mode word has no storage and reads as zero
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= reg_access;
        end
    end

    assign bus_rsp = '{rdata: rdata_q, ack: ack_q};

    // mode 1 hides the cursor, every other mode shows it
    assign cursor_cfg = '{enabled:    cursor_mode != 2'b01,
                          pos:        cursor_pos,
                          scan_start: scan_start,
                          scan_end:   scan_end};

    // the master holds its request until ack and keeps access low while ack falls
    request_held_until_ack: assert property (@(posedge clk) disable iff (reset)
        bus_req.cs && bus_req.access && !bus_rsp.ack |=> $stable(bus_req));

    access_low_while_ack_falls: assert property (@(posedge clk) disable iff (reset)
        !bus_req.access && bus_rsp.ack |=> !bus_req.access);

endmodule

// File: verilog/vga_pkg.sv
package vga_pkg;

    // bus side
    localparam int addr_w = 19;

    localparam logic [2:0] reg_index_off  = 3'd2;
    localparam logic [2:0] reg_mode_off   = 3'd4;
    localparam logic [2:0] reg_status_off = 3'd5;

    localparam logic [3:0] idx_cursor_shape = 4'd10;
    localparam logic [3:0] idx_cursor_end   = 4'd11;
    localparam logic [3:0] idx_cursor_hi    = 4'd14;
    localparam logic [3:0] idx_cursor_lo    = 4'd15;

    // 640x400 text timing with both syncs active low
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;
    localparam int h_sync_start = h_visible + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync;

    localparam int v_visible = 400;
    localparam int v_front   = 12;
    localparam int v_sync    = 2;
    localparam int v_back    = 35;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;
    localparam int v_sync_start = v_visible + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    localparam int h_count_w = $clog2(h_total);
    localparam int v_count_w = $clog2(v_total);

    // character cells
    localparam int char_w       = 8;
    localparam int char_h       = 16;
    localparam int text_cols    = 80;
    localparam int text_rows    = 25;
    localparam int cursor_pos_w = 15;

    localparam int px_w   = $clog2(char_w);
    localparam int scan_w = $clog2(char_h);
    localparam int col_w  = 7;
    localparam int row_w  = 5;

    typedef struct packed {
        logic              cs;
        logic [addr_w:1]   addr;
        logic [15:0]       wdata;
        logic [1:0]        bytesel;
        logic              wr_en;
        logic              access;
    } bus_req_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic        ack;
    } bus_rsp_t;

    typedef struct packed {
        logic                    enabled;
        logic [cursor_pos_w-1:0] pos;
        logic [scan_w-1:0]       scan_start;
        logic [scan_w-1:0]       scan_end;
    } cursor_cfg_t;

    typedef struct packed {
        logic              hsync;
        logic              vsync;
        logic              de;
        logic [col_w-1:0]  col;
        logic [row_w-1:0]  row;
        logic [scan_w-1:0] scan;
        logic              new_line;
        logic              new_frame;
    } beam_t;

endpackage
